//--- source/msx_pkg.sv
// Shared widths, status word layout and routing structs for the MSX board glue.
// Status bits above 10 are reserved here and are not decoded by any block.
`default_nettype none

package msx_pkg;

   // ========================================
   // Widths
   // ========================================
   localparam int hdmi_dim_w  = 12;
   localparam int crop_w      = 10;
   // Aspect ratio value width, the ports carry one extra flag bit on top
   localparam int arx_w       = 12;
   localparam int ddr3_addr_w = 28;
   localparam int ram_addr_w  = 27;
   localparam int bram_addr_w = 18;

   // Download index of a cassette image, compared on the low six bits
   localparam logic [5:0] cas_index = 6'd5;

   // Tape input source as seen in status bit 8
   typedef enum logic {
      cas_src_file = 1'b0,
      cas_src_adc  = 1'b1
   } cas_src_e;

   // ========================================
   // Status word from the host frame
   // ========================================
   typedef struct packed {
      logic [52:0] reserved;
      logic        detach;
      logic        tape_rewind;
      cas_src_e    tape_src;
      logic        vcrop_en;
      logic [1:0]  scale;
      logic [1:0]  scanlines;
      logic [1:0]  aspect;
      logic        reset_req;
   } status_t;

   // Video settings slice of the status word
   typedef struct packed {
      logic [1:0] aspect;
      logic [1:0] scanlines;
      logic [1:0] scale;
      logic       vcrop_en;
   } video_cfg_t;

   // ========================================
   // Memory routing
   // ========================================
   typedef struct packed {
      logic [ddr3_addr_w-1:0] addr;
      logic                   rd;
   } ddr3_req_t;

   // CPU side request, rnw high for a read
   typedef struct packed {
      logic [ram_addr_w-1:0] addr;
      logic [7:0]            din;
      logic                  rnw;
      logic                  sdram_ce;
      logic                  bram_ce;
   } cpu_mem_t;

   // Uploader request, either SDRAM or block RAM is the target
   typedef struct packed {
      logic [ram_addr_w-1:0] addr;
      logic [7:0]            din;
      logic                  ce;
      logic                  sdram_rq;
      logic                  bram_rq;
   } upload_mem_t;

   typedef struct packed {
      logic [bram_addr_w-1:0] addr;
      logic                   we;
      logic [7:0]             data;
   } bram_port_t;

endpackage

`default_nettype wire

//--- source/system_control.sv
// System reset combination and tape control, purely combinational.
// sys_reset is held high for as long as rst_n is low.
`timescale 1ns/100ps
`default_nettype none

module system_control (
   input  logic             rst_n,
   input  logic             board_reset,
   input  msx_pkg::status_t status,
   input  logic             reset_rq,
   input  logic             ioctl_download,
   input  logic [15:0]      ioctl_index,
   input  logic             cas_dout,
   input  logic             adc_bit,
   input  logic             adc_active,
   input  logic             motor,
   output logic             sys_reset,
   output logic             cas_audio_in,
   output logic             play,
   output logic             rewind
);

   logic cas_download;
   logic adc_tape;

   // ========================================
   // Reset
   // ========================================
   // Board, menu reset, detach and loader request all restart the machine
   assign sys_reset = ~rst_n | board_reset | status.reset_req | status.detach | reset_rq;

   // ========================================
   // Tape
   // ========================================
   // ADC level only counts while the reader sees a signal
   assign adc_tape = adc_bit & adc_active;

   always_comb begin
      if (status.tape_src == msx_pkg::cas_src_file) begin
         cas_audio_in = cas_dout;
      end else begin
         cas_audio_in = adc_tape;
      end
   end

   // A fresh cassette image restarts the player from the top
   assign cas_download = ioctl_download & (ioctl_index[5:0] == msx_pkg::cas_index);

   // Motor line from the MSX is active low
   assign play   = ~motor;
   assign rewind = status.tape_rewind | cas_download | sys_reset;

endmodule

`default_nettype wire

//--- source/sd_route.sv
// SD SPI routing between the physical slot and a mounted card image.
// The image is chosen on a mount pulse when its size is nonzero.
// Activity stays lit for act_timeout cycles after the last MOSI or MISO edge.
`timescale 1ns/100ps
`default_nettype none

module sd_route #(
   parameter int act_timeout = 1000000
) (
   input  logic        clk21m,
   input  logic        rst_n,
   input  logic        clear,
   input  logic        img_mount,
   input  logic [31:0] img_size,
   input  logic        sd_clk_in,
   input  logic        sd_mosi_in,
   input  logic        vsd_miso,
   input  logic        sd_miso,
   output logic        sd_cs,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        spi_miso,
   output logic        led_user,
   output logic [1:0]  led_disk
);

   localparam int cnt_w = $clog2(act_timeout + 1);

   logic             vsd_sel;
   logic             mosi_q;
   logic             miso_q;
   logic             line_change;
   logic [cnt_w-1:0] act_cnt;
   logic             sd_act;

   // ========================================
   // Slot or image select
   // ========================================
   always_ff @(posedge clk21m) begin
      if (!rst_n || clear) begin
         vsd_sel <= 1'b0;
      end else if (img_mount) begin
         vsd_sel <= |img_size;
      end
   end

   // Physical card is deselected and its clock parked while the image is in use
   assign sd_cs    = vsd_sel;
   assign sd_sck   = sd_clk_in & ~vsd_sel;
   assign sd_mosi  = sd_mosi_in & ~vsd_sel;
   assign spi_miso = vsd_sel ? vsd_miso : sd_miso;

   // ========================================
   // Activity detector
   // ========================================
   assign line_change = (mosi_q ^ sd_mosi_in) | (miso_q ^ spi_miso);

   always_ff @(posedge clk21m) begin
      if (!rst_n) begin
         mosi_q  <= 1'b0;
         miso_q  <= 1'b0;
         act_cnt <= cnt_w'(act_timeout);
      end else begin
         mosi_q <= sd_mosi_in;
         miso_q <= spi_miso;
         if (line_change) begin
            act_cnt <= '0;
         end else if (act_cnt < act_timeout) begin
            act_cnt <= act_cnt + 1'b1;
         end
      end
   end

   assign sd_act = (act_cnt < act_timeout);

   // Image activity on the user LED, slot activity on the disk LED
   assign led_user = vsd_sel & sd_act;
   // Bit 1 hands the disk LED fully to bit 0
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

`default_nettype wire

//--- source/video_crop.sv
// Vertical crop and aspect ratio from the HDMI output size.
// Crop is only applied without the scandoubler, for the known panel heights.
// Bit 12 of arx and ary stays low, so they always carry a ratio.
`timescale 1ns/100ps
`default_nettype none

module video_crop (
   input  logic                             clk21m,
   input  logic                             rst_n,
   input  msx_pkg::video_cfg_t              cfg,
   input  logic                             forced_scandoubler,
   input  logic [msx_pkg::hdmi_dim_w-1:0]   hdmi_width,
   input  logic [msx_pkg::hdmi_dim_w-1:0]   hdmi_height,
   output logic [msx_pkg::crop_w-1:0]       crop_size,
   output logic [msx_pkg::arx_w:0]          arx,
   output logic [msx_pkg::arx_w:0]          ary,
   output logic [1:0]                       vga_sl
);

   logic                          scandoubler;
   logic [msx_pkg::hdmi_dim_w:0]  min_wide_w;
   logic [msx_pkg::crop_w-1:0]    crop_next;
   logic                          wide_next;
   logic                          wide;

   assign scandoubler = forced_scandoubler | (|cfg.scanlines);

   // Height plus half height, one extra bit so it cannot wrap
   assign min_wide_w = {1'b0, hdmi_height} + {2'b00, hdmi_height[msx_pkg::hdmi_dim_w-1:1]};

   // ========================================
   // Crop table
   // ========================================
   always_comb begin
      crop_next = '0;
      wide_next = 1'b0;
      if (!scandoubler && ({1'b0, hdmi_width} >= min_wide_w)) begin
         case (hdmi_height)
            12'd480, 12'd720, 12'd1200: crop_next = 10'd240;
            12'd600, 12'd800: begin
               crop_next = 10'd200;
               wide_next = cfg.vcrop_en;
            end
            12'd768:  crop_next = 10'd256;
            12'd1080: crop_next = 10'd216;
            default:  crop_next = '0;
         endcase
      end else if (!scandoubler && (hdmi_width >= 12'd1440)) begin
         // 4:3 modes that miss the 1.5 ratio test above
         case (hdmi_height)
            12'd1440: crop_next = 10'd240;
            12'd1536: crop_next = 10'd256;
            default:  crop_next = '0;
         endcase
      end
   end

   always_ff @(posedge clk21m) begin
      if (!rst_n) begin
         crop_size <= '0;
         wide      <= 1'b0;
      end else begin
         crop_size <= cfg.vcrop_en ? crop_next : '0;
         wide      <= wide_next;
      end
   end

   // ========================================
   // Aspect ratio
   // ========================================
   always_comb begin
      arx = '0;
      ary = '0;
      if (cfg.aspect == 2'd0) begin
         // Original ratio, narrowed for the 200 line crop
         arx[msx_pkg::arx_w-1:0] = wide ? 12'd340 : 12'd400;
         ary[msx_pkg::arx_w-1:0] = 12'd300;
      end else begin
         // Full screen or a custom ratio slot
         arx[1:0] = cfg.aspect - 2'd1;
      end
   end

   assign vga_sl = cfg.scanlines;

endmodule

`default_nettype wire

//--- source/mem_route.sv
// Memory request routing, purely combinational.
// Block-RAM addresses keep only the low bram_addr_w bits of the 27-bit address.
`timescale 1ns/100ps
`default_nettype none

module mem_route (
   input  logic                 ddr3_dl_active,
   input  msx_pkg::ddr3_req_t   ddr3_dl,
   input  msx_pkg::ddr3_req_t   ddr3_cas,
   input  msx_pkg::upload_mem_t upload,
   input  msx_pkg::cpu_mem_t    cpu,
   input  logic [7:0]           sdram_dout,
   input  logic [7:0]           bram_dout,
   output msx_pkg::ddr3_req_t   ddr3_req,
   output msx_pkg::bram_port_t  bram_a,
   output logic                 sdram_upload_req,
   output logic [7:0]           cpu_ram_dout
);

   // ========================================
   // DDR3
   // ========================================
   // ROM download has priority over the cassette player
   assign ddr3_req = ddr3_dl_active ? ddr3_dl : ddr3_cas;

   // ========================================
   // Block RAM port A
   // ========================================
   always_comb begin
      if (upload.bram_rq) begin
         bram_a.addr = upload.addr[msx_pkg::bram_addr_w-1:0];
         bram_a.data = upload.din;
         // Uploader writes follow the CPU rnw line, as on the board
         bram_a.we   = ~cpu.rnw;
      end else begin
         bram_a.addr = cpu.addr[msx_pkg::bram_addr_w-1:0];
         bram_a.data = cpu.din;
         bram_a.we   = cpu.bram_ce & ~cpu.rnw;
      end
   end

   // Uploader SDRAM channel only
   assign sdram_upload_req = upload.ce & upload.sdram_rq;

   // ========================================
   // CPU read data
   // ========================================
   always_comb begin
      if (cpu.sdram_ce) begin
         cpu_ram_dout = sdram_dout;
      end else if (cpu.bram_ce) begin
         cpu_ram_dout = bram_dout;
      end else begin
         // Open bus
         cpu_ram_dout = 8'hFF;
      end
   end

endmodule

`default_nettype wire

//--- source/msx_glue.sv
// Board glue top level between the host frame and the MSX core.
// act_timeout sets the SD activity hold time in clk21m cycles.
`timescale 1ns/100ps
`default_nettype none

module msx_glue #(
   parameter int act_timeout = 1000000
) (
   input  logic                           clk21m,
   input  logic                           rst_n,
   // System and tape
   input  logic                           board_reset,
   input  msx_pkg::status_t               status,
   input  logic                           reset_rq,
   input  logic                           ioctl_download,
   input  logic [15:0]                    ioctl_index,
   input  logic                           cas_dout,
   input  logic                           adc_bit,
   input  logic                           adc_active,
   input  logic                           motor,
   output logic                           sys_reset,
   output logic                           cas_audio_in,
   output logic                           play,
   output logic                           rewind,
   // SD card
   input  logic                           img_mount,
   input  logic [31:0]                    img_size,
   input  logic                           sd_clk_in,
   input  logic                           sd_mosi_in,
   input  logic                           vsd_miso,
   input  logic                           sd_miso,
   output logic                           sd_cs,
   output logic                           sd_sck,
   output logic                           sd_mosi,
   output logic                           spi_miso,
   output logic                           led_user,
   output logic [1:0]                     led_disk,
   // Video
   input  logic                           forced_scandoubler,
   input  logic [msx_pkg::hdmi_dim_w-1:0] hdmi_width,
   input  logic [msx_pkg::hdmi_dim_w-1:0] hdmi_height,
   output logic [msx_pkg::crop_w-1:0]     crop_size,
   output logic [msx_pkg::arx_w:0]        arx,
   output logic [msx_pkg::arx_w:0]        ary,
   output logic [1:0]                     vga_sl,
   // Memory
   input  logic                           ddr3_dl_active,
   input  msx_pkg::ddr3_req_t             ddr3_dl,
   input  msx_pkg::ddr3_req_t             ddr3_cas,
   input  msx_pkg::upload_mem_t           upload,
   input  msx_pkg::cpu_mem_t              cpu,
   input  logic [7:0]                     sdram_dout,
   input  logic [7:0]                     bram_dout,
   output msx_pkg::ddr3_req_t             ddr3_req,
   output msx_pkg::bram_port_t            bram_a,
   output logic                           sdram_upload_req,
   output logic [7:0]                     cpu_ram_dout
);

   msx_pkg::video_cfg_t video_cfg;

   // Video settings slice of the status word
   assign video_cfg = '{
      aspect:    status.aspect,
      scanlines: status.scanlines,
      scale:     status.scale,
      vcrop_en:  status.vcrop_en
   };

   // ========================================
   // Blocks
   // ========================================
   system_control system_control_inst (
      .rst_n          (rst_n),
      .board_reset    (board_reset),
      .status         (status),
      .reset_rq       (reset_rq),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .cas_dout       (cas_dout),
      .adc_bit        (adc_bit),
      .adc_active     (adc_active),
      .motor          (motor),
      .sys_reset      (sys_reset),
      .cas_audio_in   (cas_audio_in),
      .play           (play),
      .rewind         (rewind)
   );

   // System reset also drops the card image selection
   sd_route #(
      .act_timeout (act_timeout)
   ) sd_route_inst (
      .clk21m     (clk21m),
      .rst_n      (rst_n),
      .clear      (sys_reset),
      .img_mount  (img_mount),
      .img_size   (img_size),
      .sd_clk_in  (sd_clk_in),
      .sd_mosi_in (sd_mosi_in),
      .vsd_miso   (vsd_miso),
      .sd_miso    (sd_miso),
      .sd_cs      (sd_cs),
      .sd_sck     (sd_sck),
      .sd_mosi    (sd_mosi),
      .spi_miso   (spi_miso),
      .led_user   (led_user),
      .led_disk   (led_disk)
   );

   video_crop video_crop_inst (
      .clk21m             (clk21m),
      .rst_n              (rst_n),
      .cfg                (video_cfg),
      .forced_scandoubler (forced_scandoubler),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .crop_size          (crop_size),
      .arx                (arx),
      .ary                (ary),
      .vga_sl             (vga_sl)
   );

   mem_route mem_route_inst (
      .ddr3_dl_active   (ddr3_dl_active),
      .ddr3_dl          (ddr3_dl),
      .ddr3_cas         (ddr3_cas),
      .upload           (upload),
      .cpu              (cpu),
      .sdram_dout       (sdram_dout),
      .bram_dout        (bram_dout),
      .ddr3_req         (ddr3_req),
      .bram_a           (bram_a),
      .sdram_upload_req (sdram_upload_req),
      .cpu_ram_dout     (cpu_ram_dout)
   );

endmodule

`default_nettype wire

//--- testbench/msx_glue_assertions.sv
// Concurrent checks on SD routing, CPU read data and reset, bound into msx_glue.
// Sampled on the rising edge of clk21m.
`timescale 1ns/100ps
`default_nettype none

module msx_glue_assertions (
   input logic              clk21m,
   input logic              rst_n,
   input logic              sd_cs,
   input logic              sd_sck,
   input msx_pkg::cpu_mem_t cpu,
   input logic [7:0]        cpu_ram_dout,
   input logic              sys_reset,
   input logic              rewind
);

   // Physical card clock parked while the image owns the SPI bus
   property sck_parked;
      @(posedge clk21m) disable iff (!rst_n) sd_cs |-> !sd_sck;
   endproperty

   // Open bus value with no chip enable
   property open_bus;
      @(posedge clk21m) disable iff (!rst_n)
         (!cpu.sdram_ce && !cpu.bram_ce) |-> (cpu_ram_dout == 8'hFF);
   endproperty

   // Holds during reset too
   property reset_rewinds;
      @(posedge clk21m) sys_reset |-> rewind;
   endproperty

   sck_parked_a: assert property (sck_parked)
      else $error("sd_sck active while sd_cs is high");

   open_bus_a: assert property (open_bus)
      else $error("cpu_ram_dout is not FF with both chip enables low");

   reset_rewinds_a: assert property (reset_rewinds)
      else $error("rewind low while sys_reset is high");

endmodule

bind msx_glue msx_glue_assertions msx_glue_assertions_inst (
   .clk21m       (clk21m),
   .rst_n        (rst_n),
   .sd_cs        (sd_cs),
   .sd_sck       (sd_sck),
   .cpu          (cpu),
   .cpu_ram_dout (cpu_ram_dout),
   .sys_reset    (sys_reset),
   .rewind       (rewind)
);

`default_nettype wire

//--- testbench/tb_msx_glue.sv
// Self-checking testbench for the MSX board glue with seeded random stimulus.
// A reference model follows every output each cycle and the first mismatch ends the run.
// Inputs change on the falling edge and are checked 10 ns later.
`timescale 1ns/100ps
`default_nettype none

module tb_msx_glue;

   localparam int act_timeout = 20;
   localparam int idle_limit  = 60;

   logic                           clk21m = 1'b0;
   logic                           rst_n;
   logic                           board_reset;
   msx_pkg::status_t               status;
   logic                           reset_rq;
   logic                           ioctl_download;
   logic [15:0]                    ioctl_index;
   logic                           cas_dout;
   logic                           adc_bit;
   logic                           adc_active;
   logic                           motor;
   logic                           sys_reset;
   logic                           cas_audio_in;
   logic                           play;
   logic                           rewind;
   logic                           img_mount;
   logic [31:0]                    img_size;
   logic                           sd_clk_in;
   logic                           sd_mosi_in;
   logic                           vsd_miso;
   logic                           sd_miso;
   logic                           sd_cs;
   logic                           sd_sck;
   logic                           sd_mosi;
   logic                           spi_miso;
   logic                           led_user;
   logic [1:0]                     led_disk;
   logic                           forced_scandoubler;
   logic [msx_pkg::hdmi_dim_w-1:0] hdmi_width;
   logic [msx_pkg::hdmi_dim_w-1:0] hdmi_height;
   logic [msx_pkg::crop_w-1:0]     crop_size;
   logic [msx_pkg::arx_w:0]        arx;
   logic [msx_pkg::arx_w:0]        ary;
   logic [1:0]                     vga_sl;
   logic                           ddr3_dl_active;
   msx_pkg::ddr3_req_t             ddr3_dl;
   msx_pkg::ddr3_req_t             ddr3_cas;
   msx_pkg::upload_mem_t           upload;
   msx_pkg::cpu_mem_t              cpu;
   logic [7:0]                     sdram_dout;
   logic [7:0]                     bram_dout;
   msx_pkg::ddr3_req_t             ddr3_req;
   msx_pkg::bram_port_t            bram_a;
   logic                           sdram_upload_req;
   logic [7:0]                     cpu_ram_dout;

   // Reference model state updated once per rising edge
   logic                       m_sel;
   logic                       m_mosi_q;
   logic                       m_miso_q;
   int                         m_cnt;
   logic [msx_pkg::crop_w-1:0] m_crop;
   logic                       m_wide;

   int heights [10] = '{480, 720, 1200, 600, 800, 768, 1080, 1440, 1536, 1000};
   int widths  [5]  = '{1920, 2560, 1440, 1024, 640};

   msx_glue #(
      .act_timeout (act_timeout)
   ) msx_glue_inst (.*);

   initial begin
      forever #50 clk21m = ~clk21m;
   end

   // ========================================
   // Error handling and compare tasks
   // ========================================
   task automatic fail_run();
      $display("Simulation failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_two(input string name, input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_crop(input string name, input logic [msx_pkg::crop_w-1:0] got,
                             input logic [msx_pkg::crop_w-1:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_ratio(input string name, input logic [msx_pkg::arx_w:0] got,
                              input logic [msx_pkg::arx_w:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_ddr3(input string name, input msx_pkg::ddr3_req_t got,
                             input msx_pkg::ddr3_req_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_bram(input string name, input msx_pkg::bram_port_t got,
                             input msx_pkg::bram_port_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
         fail_run();
      end
   endtask

   // ========================================
   // Reference model
   // ========================================
   function automatic logic model_sys_reset();
      return !rst_n || board_reset || status.reset_req || status.detach || reset_rq;
   endfunction

   // Crop table keyed by the HDMI height
   task automatic video_model(output logic [msx_pkg::crop_w-1:0] crop, output logic wide);
      logic doubler;
      logic ratio_ok;
      doubler  = forced_scandoubler || (status.scanlines != 2'd0);
      ratio_ok = (2 * int'(hdmi_width)) >= (3 * int'(hdmi_height));
      crop     = '0;
      wide     = 1'b0;
      if (!doubler && ratio_ok) begin
         case (int'(hdmi_height))
            480, 720, 1200: crop = 10'd240;
            600, 800: begin
               crop = 10'd200;
               wide = status.vcrop_en;
            end
            768:     crop = 10'd256;
            1080:    crop = 10'd216;
            default: crop = '0;
         endcase
      end else if (!doubler && int'(hdmi_width) >= 1440) begin
         if (int'(hdmi_height) == 1440) begin
            crop = 10'd240;
         end else if (int'(hdmi_height) == 1536) begin
            crop = 10'd256;
         end
      end
   endtask

   // Mirrors the rising edge that has just passed with the inputs still at their old values
   task automatic model_update();
      logic                       miso_now;
      logic                       change;
      logic [msx_pkg::crop_w-1:0] crop;
      logic                       wide;
      miso_now = m_sel ? vsd_miso : sd_miso;
      change   = (m_mosi_q != sd_mosi_in) || (m_miso_q != miso_now);
      video_model(crop, wide);
      if (!rst_n) begin
         m_sel    = 1'b0;
         m_mosi_q = 1'b0;
         m_miso_q = 1'b0;
         m_cnt    = act_timeout;
         m_crop   = '0;
         m_wide   = 1'b0;
      end else begin
         if (model_sys_reset()) begin
            m_sel = 1'b0;
         end else if (img_mount) begin
            m_sel = |img_size;
         end
         if (change) begin
            m_cnt = 0;
         end else if (m_cnt < act_timeout) begin
            m_cnt++;
         end
         m_mosi_q = sd_mosi_in;
         m_miso_q = miso_now;
         m_crop   = status.vcrop_en ? crop : '0;
         m_wide   = wide;
      end
   endtask

   task automatic check_all();
      logic                    exp_rst;
      logic                    act;
      logic [msx_pkg::arx_w:0] exp_arx;
      logic [msx_pkg::arx_w:0] exp_ary;
      msx_pkg::bram_port_t     exp_bram;
      logic [7:0]              exp_dout;
      exp_rst = model_sys_reset();
      act     = (m_cnt < act_timeout);
      check_bit("sys_reset", sys_reset, exp_rst);
      check_bit("cas_audio_in", cas_audio_in,
                (status.tape_src == msx_pkg::cas_src_file) ? cas_dout : (adc_bit && adc_active));
      check_bit("play", play, !motor);
      check_bit("rewind", rewind, status.tape_rewind || exp_rst ||
                (ioctl_download && ioctl_index[5:0] == msx_pkg::cas_index));
      // SD card
      check_bit("sd_cs", sd_cs, m_sel);
      check_bit("sd_sck", sd_sck, sd_clk_in && !m_sel);
      check_bit("sd_mosi", sd_mosi, sd_mosi_in && !m_sel);
      check_bit("spi_miso", spi_miso, m_sel ? vsd_miso : sd_miso);
      check_bit("led_user", led_user, m_sel && act);
      check_two("led_disk", led_disk, {1'b1, !m_sel && act});
      // Video
      exp_arx = '0;
      exp_ary = '0;
      if (status.aspect == 2'd0) begin
         exp_arx = m_wide ? 13'd340 : 13'd400;
         exp_ary = 13'd300;
      end else begin
         exp_arx = 13'(status.aspect) - 13'd1;
      end
      check_crop("crop_size", crop_size, m_crop);
      check_ratio("arx", arx, exp_arx);
      check_ratio("ary", ary, exp_ary);
      check_two("vga_sl", vga_sl, status.scanlines);
      // Memory
      check_ddr3("ddr3_req", ddr3_req, ddr3_dl_active ? ddr3_dl : ddr3_cas);
      if (upload.bram_rq) begin
         exp_bram = '{addr: upload.addr[17:0], we: !cpu.rnw, data: upload.din};
      end else begin
         exp_bram = '{addr: cpu.addr[17:0], we: cpu.bram_ce && !cpu.rnw, data: cpu.din};
      end
      check_bram("bram_a", bram_a, exp_bram);
      check_bit("sdram_upload_req", sdram_upload_req, upload.ce && upload.sdram_rq);
      if (cpu.sdram_ce) begin
         exp_dout = sdram_dout;
      end else if (cpu.bram_ce) begin
         exp_dout = bram_dout;
      end else begin
         exp_dout = 8'hFF;
      end
      check_byte("cpu_ram_dout", cpu_ram_dout, exp_dout);
   endtask

   // ========================================
   // Stimulus helpers
   // ========================================
   task automatic next_cycle();
      @(negedge clk21m);
      model_update();
   endtask

   task automatic settle_and_check();
      #10;
      check_all();
   endtask

   task automatic init_inputs();
      rst_n = 1'b0;
      {board_reset, reset_rq, ioctl_download, cas_dout, adc_bit, adc_active, motor} = '0;
      status      = '0;
      ioctl_index = '0;
      {img_mount, sd_clk_in, sd_mosi_in, vsd_miso, sd_miso} = '0;
      img_size    = '0;
      forced_scandoubler = 1'b0;
      hdmi_width  = '0;
      hdmi_height = '0;
      ddr3_dl_active = 1'b0;
      ddr3_dl     = '0;
      ddr3_cas    = '0;
      upload      = '0;
      cpu         = '0;
      sdram_dout  = '0;
      bram_dout   = '0;
      {m_sel, m_mosi_q, m_miso_q, m_wide} = '0;
      m_cnt  = act_timeout;
      m_crop = '0;
   endtask

   task automatic drive_sd_random();
      img_mount  = ($urandom() % 4) == 0;
      img_size   = (($urandom() % 2) == 0) ? $urandom() : 32'd0;
      sd_clk_in  = 1'($urandom());
      sd_mosi_in = 1'($urandom());
      vsd_miso   = 1'($urandom());
      sd_miso    = 1'($urandom());
   endtask

   task automatic drive_mem_random();
      ddr3_dl_active = 1'($urandom());
      ddr3_dl    = 29'($urandom());
      ddr3_cas   = 29'($urandom());
      upload     = 38'({$urandom(), $urandom()});
      cpu        = 38'({$urandom(), $urandom()});
      sdram_dout = 8'($urandom());
      bram_dout  = 8'($urandom());
   endtask

   task automatic drive_tape_random();
      status         = {$urandom(), $urandom()};
      board_reset    = ($urandom() % 8) == 0;
      reset_rq       = ($urandom() % 8) == 0;
      ioctl_download = 1'($urandom());
      ioctl_index    = 16'($urandom());
      if (($urandom() % 2) == 0) begin
         ioctl_index[5:0] = msx_pkg::cas_index;
      end
      motor      = 1'($urandom());
      cas_dout   = 1'($urandom());
      adc_bit    = 1'($urandom());
      adc_active = 1'($urandom());
   endtask

   // ========================================
   // Test sequence
   // ========================================
   initial begin
      int idle;
      void'($urandom(32'hd11f_2c06));
      init_inputs();
      repeat (2) begin
         next_cycle();
         settle_and_check();
      end
      next_cycle();
      rst_n = 1'b1;
      settle_and_check();

      // After reset
      check_bit("led_user", led_user, 1'b0);
      check_two("led_disk", led_disk, 2'b10);
      check_crop("crop_size", crop_size, '0);
      check_bit("sd_cs", sd_cs, 1'b0);

      // SD routing with random mounts
      repeat (200) begin
         next_cycle();
         drive_sd_random();
         settle_and_check();
      end

      // Activity timeout on the slot and then on the image
      for (int sel_v = 0; sel_v < 2; sel_v++) begin
         next_cycle();
         img_mount = 1'b1;
         img_size  = 32'(sel_v);
         settle_and_check();
         next_cycle();
         img_mount = 1'b0;
         settle_and_check();
         repeat (6) begin
            next_cycle();
            sd_mosi_in = ~sd_mosi_in;
            settle_and_check();
         end
         idle = 0;
         do begin
            next_cycle();
            settle_and_check();
            idle++;
         end while ((led_user || led_disk[0]) && idle < idle_limit);
         if (idle >= idle_limit) begin
            $display("Timeout: SD activity LED did not go dark after the lines went idle");
            fail_run();
         end
      end

      // Video crop sweep
      foreach (heights[i]) begin
         foreach (widths[j]) begin
            next_cycle();
            hdmi_height        = 12'(heights[i]);
            hdmi_width         = 12'(widths[j]);
            status.aspect      = 2'($urandom());
            status.scanlines   = (($urandom() % 3) == 0) ? 2'($urandom()) : 2'd0;
            status.scale       = 2'($urandom());
            status.vcrop_en    = ($urandom() % 4) != 0;
            forced_scandoubler = ($urandom() % 6) == 0;
            settle_and_check();
         end
      end

      // Memory routing
      repeat (200) begin
         next_cycle();
         drive_mem_random();
         settle_and_check();
      end

      // Tape and reset
      repeat (200) begin
         next_cycle();
         drive_tape_random();
         settle_and_check();
      end

      next_cycle();
      settle_and_check();
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
source/msx_pkg.sv
source/system_control.sv
source/sd_route.sv
source/video_crop.sv
source/mem_route.sv
source/msx_glue.sv
testbench/msx_glue_assertions.sv
testbench/tb_msx_glue.sv

//--- Makefile
# Verilator build of the MSX board glue testbench
TOP := tb_msx_glue
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f --Mdir obj_dir -o V$(TOP)

run: compile
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation passed" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
